// ==== lsq_macros.svh ====
/*
 * Load/store queue sizing constants
 * Queue and store buffer depths, address widths and the physical memory limit
 */

`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// Number of load/store queue entries
`define LSQ_DEPTH       8

// Stores held while waiting for commit
`define SB_DEPTH        2

// Sign-extended virtual address bits (Sv39)
`define LSQ_VA_BITS     39

`define LSQ_PPN_BITS    28  // Physical page number
`define LSQ_GL_BITS     5   // Global instruction index

// First invalid physical address with translation off
`define LSQ_PHYS_LIMIT  40'h80_0000_0000

`endif

// ==== lsq_pkg.sv ====
/*
 * Load/store queue types
 * Memory instruction, exception and data TLB request/response formats
 */

`default_nettype none

`include "lsq_macros.svh"

package lsq_pkg;

    typedef enum logic {
        LOAD,
        STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

    // Memory exception causes, load and store flavors
    typedef enum logic [2:0] {
        LD_MISALIGNED,
        ST_MISALIGNED,
        LD_ACCESS_FAULT,
        ST_ACCESS_FAULT,
        LD_PAGE_FAULT,
        ST_PAGE_FAULT
    } xcpt_cause_e;

    typedef logic [`LSQ_GL_BITS-1:0]       gl_index_t;
    typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_ptr_t;
    typedef logic [$clog2(`LSQ_DEPTH):0]   lsq_cnt_t;   // Holds 0..LSQ_DEPTH

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        logic [63:0] origin;        // Faulting virtual address
    } xcpt_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        mem_size_e   size;
        gl_index_t   gl_index;
        logic [63:0] addr;          // Virtual, physical once translated
        logic [63:0] data;
        logic        translated;
        xcpt_t       ex;
    } mem_instr_t;

    typedef struct packed {
        logic                     valid;
        logic                     vm_enable;
        logic                     store;
        logic [`LSQ_PPN_BITS-1:0] vpn;
    } tlb_req_t;

    typedef struct packed {
        logic                     ready;
        logic                     miss;
        logic [`LSQ_PPN_BITS-1:0] ppn;
        logic                     ld_fault;
        logic                     st_fault;
    } tlb_resp_t;

endpackage

`default_nettype wire

// ==== lsq_translate.sv ====
/*
 * Load/store queue translation stage
 * Sends the oldest untranslated instruction to the data TLB, builds the
 * physical address and classifies memory exceptions
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module lsq_translate (
    input  wire logic               en_translation_i,
    input  wire lsq_pkg::mem_instr_t instr_i,
    input  wire lsq_pkg::mem_instr_t pending_i,
    input  wire logic               pending_valid_i,
    input  wire logic               full_i,
    input  wire lsq_pkg::tlb_resp_t tlb_resp_i,
    output lsq_pkg::tlb_req_t       tlb_req_o,
    output lsq_pkg::mem_instr_t     translated_o,
    output logic                    translate_en_o,
    output logic                    take_incoming_o
);

    lsq_pkg::mem_instr_t  to_xlat;
    lsq_pkg::xcpt_cause_e cause;
    logic [63:0]          phys_addr;
    logic [63:`LSQ_VA_BITS-1] va_upper;
    logic                 is_store;
    logic                 misaligned;
    logic                 access_fault;
    logic                 xcpt_hit;

    // Incoming goes straight to the TLB only when nothing older waits
    assign take_incoming_o = instr_i.valid & ~pending_valid_i & ~full_i;
    assign to_xlat         = take_incoming_o ? instr_i : pending_i;
    assign is_store        = (to_xlat.op == lsq_pkg::STORE);

    assign translate_en_o = tlb_resp_i.ready & ~tlb_resp_i.miss &
                            (take_incoming_o | pending_valid_i);

    assign tlb_req_o.valid     = take_incoming_o | pending_valid_i;
    assign tlb_req_o.vm_enable = en_translation_i;
    assign tlb_req_o.store     = is_store;
    assign tlb_req_o.vpn       = to_xlat.addr[`LSQ_PPN_BITS+11:12];

    assign phys_addr = {{(52-`LSQ_PPN_BITS){1'b0}}, tlb_resp_i.ppn, to_xlat.addr[11:0]};

    always_comb begin
        case (to_xlat.size)
            lsq_pkg::HALF:   misaligned = to_xlat.addr[0];
            lsq_pkg::WORD:   misaligned = |to_xlat.addr[1:0];
            lsq_pkg::DOUBLE: misaligned = |to_xlat.addr[2:0];
            default:         misaligned = 1'b0;
        endcase
    end

    // Upper bits must all copy the top VA bit
    assign va_upper     = to_xlat.addr[63:`LSQ_VA_BITS-1];
    assign access_fault = en_translation_i ? ~((&va_upper) | ~(|va_upper))
                                           : (to_xlat.addr >= `LSQ_PHYS_LIMIT);

    always_comb begin
        xcpt_hit = 1'b1;
        if (misaligned) begin
            cause = is_store ? lsq_pkg::ST_MISALIGNED : lsq_pkg::LD_MISALIGNED;
        end else if (access_fault) begin
            cause = is_store ? lsq_pkg::ST_ACCESS_FAULT : lsq_pkg::LD_ACCESS_FAULT;
        end else if (is_store & tlb_resp_i.st_fault) begin
            cause = lsq_pkg::ST_PAGE_FAULT;
        end else if (~is_store & tlb_resp_i.ld_fault) begin
            cause = lsq_pkg::LD_PAGE_FAULT;
        end else begin
            xcpt_hit = 1'b0;
            cause    = lsq_pkg::LD_MISALIGNED;  // Don't care
        end
    end

    always_comb begin
        translated_o            = to_xlat;
        translated_o.addr       = phys_addr;
        translated_o.translated = translate_en_o;
        translated_o.ex         = '0;
        if (xcpt_hit) begin
            translated_o.ex.valid  = 1'b1;
            translated_o.ex.cause  = cause;
            translated_o.ex.origin = to_xlat.addr;  // Virtual address
        end
    end

endmodule

`default_nettype wire

// ==== lsq_queue.sv ====
/*
 * Load/store queue storage
 * Circular buffer with tail, translate and head pointers and separate
 * counts of untranslated and translated entries
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module lsq_queue (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire lsq_pkg::mem_instr_t instr_i,
    input  wire lsq_pkg::mem_instr_t translated_i,
    input  wire logic                translate_en_i,
    input  wire logic                take_incoming_i,
    input  wire logic                head_pop_i,
    output lsq_pkg::mem_instr_t      pending_o,
    output logic                     pending_valid_o,
    output lsq_pkg::mem_instr_t      head_o,
    output logic                     head_valid_o,
    output logic                     full_o,
    output logic                     empty_o
);

    lsq_pkg::mem_instr_t entries [`LSQ_DEPTH];

    lsq_pkg::lsq_ptr_t tail;        // Next free entry
    lsq_pkg::lsq_ptr_t xlat_ptr;    // Oldest untranslated entry
    lsq_pkg::lsq_ptr_t head;        // Oldest translated entry
    lsq_pkg::lsq_cnt_t num_untr;
    lsq_pkg::lsq_cnt_t num_tr;
    lsq_pkg::lsq_cnt_t occupancy;

    logic write_en;
    logic write_translated;
    logic writeback_en;

    assign occupancy = num_untr + num_tr;
    assign full_o    = (occupancy == lsq_pkg::lsq_cnt_t'(`LSQ_DEPTH)) | flush_i;
    assign empty_o   = (occupancy == '0);

    assign write_en         = instr_i.valid & ~full_o;
    assign write_translated = take_incoming_i & translate_en_i;
    assign writeback_en     = translate_en_i & ~take_incoming_i & pending_valid_o;

    assign pending_valid_o = (num_untr != '0);
    assign pending_o       = entries[xlat_ptr];

    // Head is only offered once translated
    assign head_valid_o = (num_tr != '0) & ~flush_i;

    always_comb begin
        head_o       = entries[head];
        head_o.valid = head_valid_o;
    end

    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail] <= write_translated ? translated_i : instr_i;
        end
        if (writeback_en) begin
            entries[xlat_ptr] <= translated_i;  // Translate in place
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail     <= '0;
            xlat_ptr <= '0;
            head     <= '0;
            num_untr <= '0;
            num_tr   <= '0;
        end else if (flush_i) begin
            tail     <= '0;
            xlat_ptr <= '0;
            head     <= '0;
            num_untr <= '0;
            num_tr   <= '0;
        end else begin
            if (write_en) begin
                tail <= tail + 1'b1;
            end
            // Incoming translation means xlat_ptr == tail
            if (translate_en_i) begin
                xlat_ptr <= xlat_ptr + 1'b1;
            end
            if (head_pop_i) begin
                head <= head + 1'b1;
            end
            num_untr <= num_untr + lsq_pkg::lsq_cnt_t'(write_en & ~write_translated)
                                 - lsq_pkg::lsq_cnt_t'(writeback_en);
            num_tr   <= num_tr + lsq_pkg::lsq_cnt_t'(translate_en_i)
                               - lsq_pkg::lsq_cnt_t'(head_pop_i);
        end
    end

endmodule

`default_nettype wire

// ==== lsq_issue.sv ====
/*
 * Load/store queue issue arbiter
 * Picks a head load, a committed buffered store, a committed head store
 * or a spill of the head store into the store buffer
 */

`timescale 1ns/1ps
`default_nettype none

module lsq_issue (
    input  wire logic                rob_store_ack_i,
    input  wire lsq_pkg::gl_index_t  rob_store_gl_idx_i,
    input  wire logic                read_next_i,
    input  wire lsq_pkg::mem_instr_t head_i,
    input  wire logic                head_valid_i,
    input  wire lsq_pkg::mem_instr_t sb_head_i,
    input  wire logic                sb_empty_i,
    input  wire logic                sb_full_i,
    input  wire logic                collision_i,
    output logic                     head_pop_o,
    output logic                     sb_push_o,
    output logic                     sb_pop_o,
    output lsq_pkg::mem_instr_t      next_instr_o,
    output logic                     blocked_store_o,
    output logic                     pmu_load_after_store_o
);

    lsq_pkg::gl_index_t rob_idx_next;
    logic head_is_load;
    logic head_is_store;
    logic load_ok;
    logic sb_store_ok;
    logic head_store_ok;

    // Wraps modulo 2**LSQ_GL_BITS
    assign rob_idx_next = rob_store_gl_idx_i + 1'b1;

    assign head_is_load  = head_valid_i & (head_i.op == lsq_pkg::LOAD);
    assign head_is_store = head_valid_i & (head_i.op == lsq_pkg::STORE);

    assign load_ok       = head_is_load & ~collision_i;
    assign sb_store_ok   = ~sb_empty_i & rob_store_ack_i &
                           ((sb_head_i.gl_index == rob_store_gl_idx_i) |
                            (sb_head_i.gl_index == rob_idx_next));
    assign head_store_ok = head_is_store & rob_store_ack_i &
                           ((head_i.gl_index == rob_store_gl_idx_i) |
                            (head_i.gl_index == rob_idx_next));

    always_comb begin
        head_pop_o   = 1'b0;
        sb_push_o    = 1'b0;
        sb_pop_o     = 1'b0;
        next_instr_o = '0;
        if (load_ok) begin
            next_instr_o = head_i;
            head_pop_o   = read_next_i;
        end else if (sb_store_ok) begin   // Older buffered store first
            next_instr_o = sb_head_i;
            sb_pop_o     = read_next_i;
        end else if (head_store_ok) begin
            next_instr_o = head_i;
            head_pop_o   = read_next_i;
        end else if (head_is_store & ~sb_full_i) begin
            // Park the uncommitted store so later loads can go
            sb_push_o  = 1'b1;
            head_pop_o = 1'b1;
        end
    end

    assign blocked_store_o        = ~(load_ok | sb_store_ok | head_store_ok);
    assign pmu_load_after_store_o = collision_i;

endmodule

`default_nettype wire

// ==== store_buffer.sv ====
/*
 * Store buffer
 * FIFO of stores waiting for commit, flags a head load that hits a
 * buffered doubleword
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module store_buffer (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire logic                push_i,
    input  wire logic                pop_i,
    input  wire lsq_pkg::mem_instr_t instr_i,
    input  wire logic [63:0]         load_addr_i,
    output lsq_pkg::mem_instr_t      oldest_o,
    output logic                     empty_o,
    output logic                     full_o,
    output logic                     collision_o
);

    localparam int PTR_W = (`SB_DEPTH > 1) ? $clog2(`SB_DEPTH) : 1;

    lsq_pkg::mem_instr_t  entries [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] occupied;
    logic [`SB_DEPTH-1:0] addr_hit;
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic                 head_is_load;

    assign empty_o  = ~(|occupied) | flush_i;   // Nothing offered while flushing
    assign full_o   = &occupied;
    assign oldest_o = entries[rd_ptr];

    // Same doubleword as the head load
    always_comb begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            addr_hit[i] = occupied[i] & (entries[i].addr[63:3] == load_addr_i[63:3]);
        end
    end

    assign head_is_load = instr_i.valid & (instr_i.op == lsq_pkg::LOAD);
    assign collision_o  = head_is_load & (|addr_hit);

    always_ff @(posedge clk_i) begin
        if (push_i & ~full_o) begin
            entries[wr_ptr] <= instr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            occupied <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else if (flush_i) begin
            occupied <= '0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
        end else begin
            if (pop_i & ~empty_o) begin
                occupied[rd_ptr] <= 1'b0;
                rd_ptr           <= (rd_ptr == PTR_W'(`SB_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_i & ~full_o) begin
                occupied[wr_ptr] <= 1'b1;
                wr_ptr           <= (wr_ptr == PTR_W'(`SB_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== load_store_queue.sv ====
/*
 * Load/store queue top level
 * In-order memory queue with data TLB translation and a store buffer
 */

`timescale 1ns/1ps
`default_nettype none

module load_store_queue (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                flush_i,
    input  wire logic                en_translation_i,
    input  wire lsq_pkg::mem_instr_t instr_i,
    input  wire logic                read_next_i,
    input  wire logic                rob_store_ack_i,
    input  wire lsq_pkg::gl_index_t  rob_store_gl_idx_i,
    input  wire lsq_pkg::tlb_resp_t  tlb_resp_i,
    output lsq_pkg::tlb_req_t        tlb_req_o,
    output lsq_pkg::mem_instr_t      next_instr_o,
    output logic                     full_o,
    output logic                     empty_o,
    output logic                     blocked_store_o,
    output logic                     pmu_load_after_store_o
);

    lsq_pkg::mem_instr_t translated_instr;
    lsq_pkg::mem_instr_t pending_instr;
    lsq_pkg::mem_instr_t head_instr;
    lsq_pkg::mem_instr_t sb_oldest;
    logic translate_en;
    logic take_incoming;
    logic pending_valid;
    logic head_valid;
    logic head_pop;
    logic q_empty;
    logic sb_push;
    logic sb_pop;
    logic sb_empty;
    logic sb_full;
    logic sb_collision;

    assign empty_o = q_empty & sb_empty;

    lsq_translate u_translate (
        .en_translation_i (en_translation_i),
        .instr_i          (instr_i),
        .pending_i        (pending_instr),
        .pending_valid_i  (pending_valid),
        .full_i           (full_o),
        .tlb_resp_i       (tlb_resp_i),
        .tlb_req_o        (tlb_req_o),
        .translated_o     (translated_instr),
        .translate_en_o   (translate_en),
        .take_incoming_o  (take_incoming)
    );

    lsq_queue u_queue (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .flush_i         (flush_i),
        .instr_i         (instr_i),
        .translated_i    (translated_instr),
        .translate_en_i  (translate_en),
        .take_incoming_i (take_incoming),
        .head_pop_i      (head_pop),
        .pending_o       (pending_instr),
        .pending_valid_o (pending_valid),
        .head_o          (head_instr),
        .head_valid_o    (head_valid),
        .full_o          (full_o),
        .empty_o         (q_empty)
    );

    lsq_issue u_issue (
        .rob_store_ack_i        (rob_store_ack_i),
        .rob_store_gl_idx_i     (rob_store_gl_idx_i),
        .read_next_i            (read_next_i),
        .head_i                 (head_instr),
        .head_valid_i           (head_valid),
        .sb_head_i              (sb_oldest),
        .sb_empty_i             (sb_empty),
        .sb_full_i              (sb_full),
        .collision_i            (sb_collision),
        .head_pop_o             (head_pop),
        .sb_push_o              (sb_push),
        .sb_pop_o               (sb_pop),
        .next_instr_o           (next_instr_o),
        .blocked_store_o        (blocked_store_o),
        .pmu_load_after_store_o (pmu_load_after_store_o)
    );

    store_buffer u_store_buffer (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .push_i      (sb_push),
        .pop_i       (sb_pop),
        .instr_i     (head_instr),
        .load_addr_i (head_instr.addr),
        .oldest_o    (sb_oldest),
        .empty_o     (sb_empty),
        .full_o      (sb_full),
        .collision_o (sb_collision)
    );

endmodule

`default_nettype wire

// ==== lsq_assert.sv ====
/*
 * Load/store queue invariants
 * Bound into the top level
 */

`timescale 1ns/1ps
`default_nettype none

module lsq_assert (
    input wire logic                clk_i,
    input wire logic                rstn_i,
    input wire logic                flush_i,
    input wire logic                full_o,
    input wire logic                empty_o,
    input wire lsq_pkg::mem_instr_t next_instr_o
);

    full_not_empty: assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        !(full_o && empty_o))
        else $error("full and empty both high");

    // Only translated entries leave
    issue_translated: assert property (@(posedge clk_i) disable iff (!rstn_i)
        next_instr_o.valid |-> next_instr_o.translated)
        else $error("untranslated instruction issued");

    no_issue_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        next_instr_o.valid |-> !empty_o)
        else $error("issue while queue empty");

endmodule

bind load_store_queue lsq_assert u_lsq_assert (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .full_o       (full_o),
    .empty_o      (empty_o),
    .next_instr_o (next_instr_o)
);

`default_nettype wire

// ==== tb_load_store_queue.sv ====
/*
 * Directed testbench for the load/store queue
 * TLB model, translation, exception, commit, store buffer and full/flush tests
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module tb_load_store_queue;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_CYCLES = 2000;   // Five short tests, well under 200 cycles each
    localparam int WAIT_LIMIT = 20;

    logic                clk_i;
    logic                rstn_i;
    logic                flush_i;
    logic                en_translation_i;
    lsq_pkg::mem_instr_t instr_i;
    logic                read_next_i;
    logic                rob_store_ack_i;
    lsq_pkg::gl_index_t  rob_store_gl_idx_i;
    lsq_pkg::tlb_resp_t  tlb_resp_i;
    lsq_pkg::tlb_req_t   tlb_req_o;
    lsq_pkg::mem_instr_t next_instr_o;
    logic                full_o;
    logic                empty_o;
    logic                blocked_store_o;
    logic                pmu_load_after_store_o;

    logic [31:0]        lfsr = 32'hc72e6e26;
    lsq_pkg::gl_index_t gl_next = '0;
    lsq_pkg::tlb_req_t  last_req = '0;     // TLB request seen while an instruction is offered
    logic               force_ld_fault = 1'b0;
    logic               force_st_fault = 1'b0;
    int                 errors = 0;
    int                 tests_run = 0;
    int                 cycles = 0;

    load_store_queue DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // TLB model, always a hit in the same cycle
    always_comb begin
        tlb_resp_i.ready    = 1'b1;
        tlb_resp_i.miss     = 1'b0;
        tlb_resp_i.ppn      = tlb_req_o.vm_enable ? (tlb_req_o.vpn ^ 28'h0000abc) : tlb_req_o.vpn;
        tlb_resp_i.ld_fault = force_ld_fault;
        tlb_resp_i.st_fault = force_st_fault;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    // Canonical doubleword-aligned address below bit 38
    function automatic logic [63:0] rand_addr();
        logic [63:0] r;
        r = rand_bits(35);
        return {26'b0, r[34:0], 3'b000};
    endfunction

    function automatic logic [63:0] expect_paddr(logic [63:0] va, logic vm);
        logic [27:0] ppn;
        ppn = vm ? (va[39:12] ^ 28'h0000abc) : va[39:12];
        return {24'b0, ppn, va[11:0]};
    endfunction

    function automatic lsq_pkg::mem_instr_t make_instr(lsq_pkg::mem_op_e op,
                                                       lsq_pkg::mem_size_e size,
                                                       logic [63:0] addr);
        lsq_pkg::mem_instr_t m;
        m          = '0;
        m.valid    = 1'b1;
        m.op       = op;
        m.size     = size;
        m.addr     = addr;
        m.data     = rand_bits(64);
        m.gl_index = gl_next;
        gl_next    = gl_next + 1'b1;
        return m;
    endfunction

    task automatic report_mismatch(string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic enqueue(lsq_pkg::mem_instr_t m);
        @(negedge clk_i);
        instr_i = m;
        #(CLK_PERIOD/4);
        last_req = tlb_req_o;
        @(negedge clk_i);
        instr_i.valid = 1'b0;
    endtask

    // Samples at the falling edge, then takes the item on the next rising edge
    task automatic take_issue(output lsq_pkg::mem_instr_t got, output logic found);
        found = 1'b0;
        got   = '0;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(negedge clk_i);
            if (next_instr_o.valid) begin
                got         = next_instr_o;
                found       = 1'b1;
                read_next_i = 1'b1;
            end
        end
        @(negedge clk_i);
        read_next_i = 1'b0;
        if (!found) begin
            $display("No instruction was issued within %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errs_before);
        tests_run++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "errors");
    endtask

    task automatic load_translate_test();
        lsq_pkg::mem_instr_t m;
        lsq_pkg::mem_instr_t got;
        logic found;
        int e0;
        e0 = errors;
        m  = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, rand_addr());
        enqueue(m);
        if (!last_req.valid || last_req.store || !last_req.vm_enable)
            report_mismatch("TLB request flags wrong for load");
        if (last_req.vpn != m.addr[39:12])
            report_mismatch("TLB request page number wrong");
        take_issue(got, found);
        if (got.op != lsq_pkg::LOAD)
            report_mismatch("issued op is not a load");
        if (got.addr != expect_paddr(m.addr, 1'b1))
            report_mismatch("load physical address wrong");
        if (!got.translated)
            report_mismatch("load not marked translated");
        if (got.ex.valid)
            report_mismatch("unexpected exception on load");
        finish_test("load_translate", e0);
    endtask

    task automatic exception_test();
        lsq_pkg::mem_instr_t m;
        lsq_pkg::mem_instr_t got;
        logic found;
        int e0;
        e0 = errors;
        m  = make_instr(lsq_pkg::LOAD, lsq_pkg::WORD, rand_addr() | 64'h2);
        enqueue(m);
        take_issue(got, found);
        if (!got.ex.valid || got.ex.cause != lsq_pkg::LD_MISALIGNED)
            report_mismatch("no LD_MISALIGNED");
        if (got.ex.origin != m.addr)
            report_mismatch("misaligned origin wrong");

        m = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, rand_addr());
        force_ld_fault = 1'b1;
        enqueue(m);
        take_issue(got, found);
        force_ld_fault = 1'b0;
        if (!got.ex.valid || got.ex.cause != lsq_pkg::LD_PAGE_FAULT)
            report_mismatch("no LD_PAGE_FAULT");
        if (got.ex.origin != m.addr)
            report_mismatch("load page fault origin wrong");

        // Bit 39 set without the upper bits
        m = make_instr(lsq_pkg::STORE, lsq_pkg::DOUBLE, 64'h0000_0080_0000_1000);
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = m.gl_index;
        enqueue(m);
        take_issue(got, found);
        if (!got.ex.valid || got.ex.cause != lsq_pkg::ST_ACCESS_FAULT)
            report_mismatch("no ST_ACCESS_FAULT");
        if (got.ex.origin != m.addr)
            report_mismatch("access fault origin wrong");

        m = make_instr(lsq_pkg::STORE, lsq_pkg::DOUBLE, rand_addr());
        rob_store_gl_idx_i = m.gl_index;
        force_st_fault     = 1'b1;
        enqueue(m);
        if (!last_req.valid || !last_req.store)
            report_mismatch("TLB request flags wrong for store");
        take_issue(got, found);
        force_st_fault  = 1'b0;
        rob_store_ack_i = 1'b0;
        if (!got.ex.valid || got.ex.cause != lsq_pkg::ST_PAGE_FAULT)
            report_mismatch("no ST_PAGE_FAULT");
        if (got.ex.origin != m.addr)
            report_mismatch("page fault origin wrong");
        finish_test("exceptions", e0);
    endtask

    task automatic store_commit_test();
        lsq_pkg::mem_instr_t m;
        lsq_pkg::mem_instr_t got;
        logic found;
        int e0;
        e0 = errors;
        m  = make_instr(lsq_pkg::STORE, lsq_pkg::DOUBLE, rand_addr());
        enqueue(m);
        repeat (4) begin
            @(negedge clk_i);
            if (next_instr_o.valid)
                report_mismatch("store issued without commit");
            if (!blocked_store_o)
                report_mismatch("blocked_store_o low while store waits");
        end
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = m.gl_index;
        take_issue(got, found);
        if (got.op != lsq_pkg::STORE || got.gl_index != m.gl_index)
            report_mismatch("wrong store issued");
        if (got.addr != expect_paddr(m.addr, 1'b1))
            report_mismatch("store physical address wrong");
        repeat (3) begin
            @(negedge clk_i);
            if (next_instr_o.valid)
                report_mismatch("store issued twice");
        end
        rob_store_ack_i = 1'b0;
        finish_test("store_commit", e0);
    endtask

    task automatic load_after_store_test();
        lsq_pkg::mem_instr_t st;
        lsq_pkg::mem_instr_t ld;
        lsq_pkg::mem_instr_t got;
        logic found;
        int e0;
        e0 = errors;
        st = make_instr(lsq_pkg::STORE, lsq_pkg::DOUBLE, rand_addr());
        ld = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, st.addr ^ 64'h8);
        enqueue(st);
        enqueue(ld);
        take_issue(got, found);
        if (got.op != lsq_pkg::LOAD || got.addr != expect_paddr(ld.addr, 1'b1))
            report_mismatch("load did not pass the buffered store");
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = st.gl_index;
        take_issue(got, found);
        if (got.op != lsq_pkg::STORE || got.gl_index != st.gl_index)
            report_mismatch("buffered store lost");
        rob_store_ack_i = 1'b0;

        // Same doubleword must wait for the store
        st = make_instr(lsq_pkg::STORE, lsq_pkg::DOUBLE, rand_addr());
        ld = make_instr(lsq_pkg::LOAD, lsq_pkg::WORD, st.addr | 64'h4);
        enqueue(st);
        enqueue(ld);
        found = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !found; i++) begin
            @(negedge clk_i);
            found = pmu_load_after_store_o;
        end
        if (!found)
            report_mismatch("pmu_load_after_store_o never raised");
        if (next_instr_o.valid)
            report_mismatch("colliding load issued before store");
        rob_store_ack_i    = 1'b1;
        rob_store_gl_idx_i = st.gl_index;
        take_issue(got, found);
        if (got.op != lsq_pkg::STORE || got.gl_index != st.gl_index)
            report_mismatch("store not issued first");
        take_issue(got, found);
        if (got.op != lsq_pkg::LOAD || got.addr != expect_paddr(ld.addr, 1'b1))
            report_mismatch("load after store wrong");
        rob_store_ack_i = 1'b0;
        finish_test("load_after_store", e0);
    endtask

    task automatic full_flush_test();
        lsq_pkg::mem_instr_t first;
        lsq_pkg::mem_instr_t m;
        int e0;
        e0    = errors;
        first = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, rand_addr());
        enqueue(first);
        for (int i = 1; i < `LSQ_DEPTH; i++) begin
            m = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, rand_addr());
            enqueue(m);
        end
        @(negedge clk_i);
        if (!full_o)
            report_mismatch("full_o low with all entries used");
        m = make_instr(lsq_pkg::LOAD, lsq_pkg::DOUBLE, rand_addr());
        enqueue(m);
        if (!full_o)
            report_mismatch("full_o dropped after extra enqueue");
        if (!next_instr_o.valid || next_instr_o.addr != expect_paddr(first.addr, 1'b1))
            report_mismatch("head changed while full");
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        @(negedge clk_i);
        if (!empty_o)
            report_mismatch("empty_o low after flush");
        if (next_instr_o.valid)
            report_mismatch("valid output after flush");
        finish_test("full_flush", e0);
    endtask

    initial begin
        rstn_i             = 1'b0;
        flush_i            = 1'b0;
        en_translation_i   = 1'b1;
        instr_i            = '0;
        read_next_i        = 1'b0;
        rob_store_ack_i    = 1'b0;
        rob_store_gl_idx_i = '0;
        repeat (5) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        if (!empty_o || next_instr_o.valid)
            report_mismatch("queue not empty after reset");
        if (!blocked_store_o || pmu_load_after_store_o)
            report_mismatch("status flags wrong after reset");

        load_translate_test();
        exception_test();
        store_commit_test();
        load_after_store_test();
        full_flush_test();

        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== load_store_queue.f ====
+incdir+.
lsq_pkg.sv
lsq_translate.sv
lsq_queue.sv
lsq_issue.sv
store_buffer.sv
load_store_queue.sv
lsq_assert.sv
tb_load_store_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_load_store_queue
RTL_TOP   ?= load_store_queue
FLIST     ?= load_store_queue.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
